/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ultrasonic_floor_tb
FILELIST  = ultrasonic_floor.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/echo_bcd_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module echo_bcd_counter (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                count_clear,
    input  logic                                count_enable,
    input  logic                                store,
    output ultrasonic_floor_pkg::distance_bcd_t distance
);

    localparam int presc_w = $clog2(`CM_CYCLES);

    logic [presc_w-1:0]              presc;
    logic                            cm_tick;
    logic                            at_max;
    ultrasonic_floor_pkg::bcd_digit_t units;
    ultrasonic_floor_pkg::bcd_digit_t tens;
    ultrasonic_floor_pkg::bcd_digit_t hundreds;

    // One tick for every CM_CYCLES enabled clocks
    assign cm_tick = count_enable && (presc == presc_w'(`CM_CYCLES - 1));

    assign at_max = ultrasonic_floor_pkg::bcd_to_cm({hundreds, tens, units}) >= 10'(`MAX_CM);

    // ====================
    // Prescaler
    // ====================

    always_ff @(posedge clock) begin
        if (reset || count_clear) begin
            presc <= '0;
        end else if (count_enable) begin
            if (cm_tick) begin
                presc <= '0;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

    // ====================
    // BCD digits
    // ====================

    // Units carry into tens and tens into hundreds, the count holds at MAX_CM
    always_ff @(posedge clock) begin
        if (reset || count_clear) begin
            units    <= 4'd0;
            tens     <= 4'd0;
            hundreds <= 4'd0;
        end else if (cm_tick && !at_max) begin
            if (units == 4'd9) begin
                units <= 4'd0;
                if (tens == 4'd9) begin
                    tens     <= 4'd0;
                    hundreds <= hundreds + 4'd1;
                end else begin
                    tens <= tens + 4'd1;
                end
            end else begin
                units <= units + 4'd1;
            end
        end
    end

    // The displays follow this register, so they only change after an echo ends
    always_ff @(posedge clock) begin
        if (reset) begin
            distance <= '0;
        end else if (store) begin
            distance <= {hundreds, tens, units};
        end
    end

endmodule

`default_nettype wire

/* rtl/floor_converter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module floor_converter (
    input  ultrasonic_floor_pkg::distance_bcd_t distance,
    output ultrasonic_floor_pkg::floor_t        floor_level
);

    logic [9:0] distance_cm;

    assign distance_cm = ultrasonic_floor_pkg::bcd_to_cm(distance);

    // Each threshold is the lowest distance of the next floor up
    always_comb begin
        if (distance_cm < 10'(`FLOOR1_CM)) begin
            floor_level = 2'd0;
        end else if (distance_cm < 10'(`FLOOR2_CM)) begin
            floor_level = 2'd1;
        end else if (distance_cm < 10'(`FLOOR3_CM)) begin
            floor_level = 2'd2;
        end else begin
            floor_level = 2'd3;
        end
    end

endmodule

`default_nettype wire

/* rtl/seg7_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module seg7_decoder (
    input  ultrasonic_floor_pkg::bcd_digit_t digit,
    output ultrasonic_floor_pkg::seg7_t      segments
);

    // Bit order is g f e d c b a, a zero lights the segment
    always_comb begin
        case (digit)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            4'hf: segments = 7'b0001110;
            default: segments = 7'b1111111;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/sonar_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module sonar_control (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               measure,
    input  logic                               echo,
    input  logic                               trigger_done,
    output logic                               trigger_start,
    output logic                               count_clear,
    output logic                               count_enable,
    output logic                               store,
    output logic                               done,
    output logic                               timeout,
    output ultrasonic_floor_pkg::sonar_state_t state
);

    localparam int wait_w = $clog2(`ECHO_TIMEOUT_CYCLES);

    ultrasonic_floor_pkg::sonar_state_t state_next;

    logic              measure_d;
    logic              measure_rise;
    logic              echo_meta;
    logic              echo_sync;
    logic [wait_w-1:0] wait_count;
    logic              wait_expired;

    // Only a rising edge of measure starts a measurement
    assign measure_rise = measure && !measure_d;

    // The last waiting cycle without any echo ends the measurement
    assign wait_expired = (state == ultrasonic_floor_pkg::st_wait_echo) && !echo_sync &&
                          (wait_count == wait_w'(`ECHO_TIMEOUT_CYCLES - 1));

    // ====================
    // Next state
    // ====================

    always_comb begin
        state_next = state;
        case (state)
            ultrasonic_floor_pkg::st_idle: begin
                if (measure_rise) begin
                    state_next = ultrasonic_floor_pkg::st_trigger;
                end
            end
            ultrasonic_floor_pkg::st_trigger: begin
                if (trigger_done) begin
                    state_next = ultrasonic_floor_pkg::st_wait_echo;
                end
            end
            ultrasonic_floor_pkg::st_wait_echo: begin
                if (echo_sync) begin
                    state_next = ultrasonic_floor_pkg::st_measure;
                end else if (wait_expired) begin
                    state_next = ultrasonic_floor_pkg::st_idle;
                end
            end
            ultrasonic_floor_pkg::st_measure: begin
                if (!echo_sync) begin
                    state_next = ultrasonic_floor_pkg::st_store;
                end
            end
            ultrasonic_floor_pkg::st_store: state_next = ultrasonic_floor_pkg::st_done;
            ultrasonic_floor_pkg::st_done:  state_next = ultrasonic_floor_pkg::st_idle;
            default:                        state_next = ultrasonic_floor_pkg::st_idle;
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= ultrasonic_floor_pkg::st_idle;
            measure_d     <= 1'b0;
            echo_meta     <= 1'b0;
            echo_sync     <= 1'b0;
            trigger_start <= 1'b0;
            count_clear   <= 1'b0;
            timeout       <= 1'b0;
            wait_count    <= '0;
        end else begin
            state     <= state_next;
            measure_d <= measure;
            echo_meta <= echo;
            echo_sync <= echo_meta;

            // Start the trigger and clear the old count in the same cycle
            trigger_start <= (state == ultrasonic_floor_pkg::st_idle) && measure_rise;
            count_clear   <= (state == ultrasonic_floor_pkg::st_idle) && measure_rise;
            timeout       <= wait_expired;

            // The wait counter runs only while waiting for the echo
            if (state == ultrasonic_floor_pkg::st_wait_echo) begin
                wait_count <= wait_count + 1'b1;
            end else begin
                wait_count <= '0;
            end
        end
    end

    assign count_enable = (state == ultrasonic_floor_pkg::st_measure) && echo_sync;
    assign store        = (state == ultrasonic_floor_pkg::st_store);
    assign done         = (state == ultrasonic_floor_pkg::st_done);

endmodule

`default_nettype wire

/* rtl/trigger_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module trigger_timer (
    input  logic clock,
    input  logic reset,
    input  logic trigger_start,
    output logic trigger,
    output logic trigger_done
);

    localparam int count_w = $clog2(`TRIGGER_CYCLES + 1);

    logic [count_w-1:0] remaining;

    // The pulse begins on start and ends when the down-counter reaches zero
    always_ff @(posedge clock) begin
        if (reset) begin
            trigger      <= 1'b0;
            trigger_done <= 1'b0;
            remaining    <= '0;
        end else begin
            trigger_done <= 1'b0;
            if (trigger_start && !trigger) begin
                trigger   <= 1'b1;
                remaining <= count_w'(`TRIGGER_CYCLES - 1);
            end else if (trigger) begin
                if (remaining == '0) begin
                    trigger      <= 1'b0;
                    trigger_done <= 1'b1;
                end else begin
                    remaining <= remaining - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ultrasonic_floor_pkg.sv */
`default_nettype none

package ultrasonic_floor_pkg;

    // One decimal digit, also used as a hex digit for the displays
    typedef logic [3:0] bcd_digit_t;

    // Hundreds in [11:8], tens in [7:4], units in [3:0]
    typedef logic [11:0] distance_bcd_t;

    typedef logic [1:0] floor_t;

    // Segments g down to a, a low bit lights the segment
    typedef logic [6:0] seg7_t;

    // The code of each state is what the debug display shows
    typedef enum logic [3:0] {
        st_idle      = 4'd0,
        st_trigger   = 4'd1,
        st_wait_echo = 4'd2,
        st_measure   = 4'd3,
        st_store     = 4'd4,
        st_done      = 4'd5
    } sonar_state_t;

    // Binary value of a three-digit BCD distance, 0 to 999
    function automatic logic [9:0] bcd_to_cm(distance_bcd_t value);
        return 10'(value[11:8]) * 10'd100
             + 10'(value[7:4]) * 10'd10
             + 10'(value[3:0]);
    endfunction

endpackage

`default_nettype wire

/* rtl/ultrasonic_floor_settings.svh */
`ifndef ULTRASONIC_FLOOR_SETTINGS_SVH
`define ULTRASONIC_FLOOR_SETTINGS_SVH

// ====================
// Sensor timing
// ====================

// Width of the trigger pulse in clocks, stands in for 10 us
`define TRIGGER_CYCLES 10

// Clocks of echo-high time per centimetre
// A board build overrides this one on the command line
`define CM_CYCLES 20

// Clocks to wait for the echo after the trigger has ended
`define ECHO_TIMEOUT_CYCLES 200

// ====================
// Floor map
// ====================

// Lower bound of floors 1, 2 and 3 in centimetres
`define FLOOR1_CM 10
`define FLOOR2_CM 20
`define FLOOR3_CM 30

// Largest distance the counter can show
`define MAX_CM 999

`endif

/* rtl/ultrasonic_floor_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ultrasonic_floor_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         measure,
    input  logic                         echo,
    output logic                         trigger,
    output ultrasonic_floor_pkg::seg7_t  hex0,
    output ultrasonic_floor_pkg::seg7_t  hex1,
    output ultrasonic_floor_pkg::seg7_t  hex2,
    output ultrasonic_floor_pkg::seg7_t  hex3,
    output ultrasonic_floor_pkg::floor_t floor_level,
    output logic                         done,
    output logic                         timeout,
    output logic                         db_measure,
    output logic                         db_echo,
    output logic                         db_trigger,
    output ultrasonic_floor_pkg::seg7_t  db_state
);

    logic                                trigger_start;
    logic                                trigger_done;
    logic                                count_clear;
    logic                                count_enable;
    logic                                store;
    ultrasonic_floor_pkg::sonar_state_t  state;
    ultrasonic_floor_pkg::distance_bcd_t distance;

    // ====================
    // Measurement path
    // ====================

    sonar_control u_control (
        .clock        (clock),
        .reset        (reset),
        .measure      (measure),
        .echo         (echo),
        .trigger_done (trigger_done),
        .trigger_start(trigger_start),
        .count_clear  (count_clear),
        .count_enable (count_enable),
        .store        (store),
        .done         (done),
        .timeout      (timeout),
        .state        (state)
    );

    trigger_timer u_trigger (
        .clock        (clock),
        .reset        (reset),
        .trigger_start(trigger_start),
        .trigger      (trigger),
        .trigger_done (trigger_done)
    );

    echo_bcd_counter u_counter (
        .clock       (clock),
        .reset       (reset),
        .count_clear (count_clear),
        .count_enable(count_enable),
        .store       (store),
        .distance    (distance)
    );

    floor_converter u_floor (
        .distance   (distance),
        .floor_level(floor_level)
    );

    // ====================
    // Displays
    // ====================

    // Floor number on hex0, padded to a full digit
    seg7_decoder u_hex0 (
        .digit   ({2'b00, floor_level}),
        .segments(hex0)
    );

    seg7_decoder u_hex1 (
        .digit   (distance[3:0]),
        .segments(hex1)
    );

    seg7_decoder u_hex2 (
        .digit   (distance[7:4]),
        .segments(hex2)
    );

    seg7_decoder u_hex3 (
        .digit   (distance[11:8]),
        .segments(hex3)
    );

    // State code for debugging the FSM on the board
    seg7_decoder u_state (
        .digit   (state),
        .segments(db_state)
    );

    assign db_measure = measure;
    assign db_echo    = echo;
    assign db_trigger = trigger;

endmodule

`default_nettype wire

/* ultrasonic_floor.f */
+incdir+rtl
rtl/ultrasonic_floor_pkg.sv
rtl/seg7_decoder.sv
rtl/trigger_timer.sv
rtl/sonar_control.sv
rtl/echo_bcd_counter.sv
rtl/floor_converter.sv
rtl/ultrasonic_floor_top.sv
verif/ultrasonic_floor_assert.sv
verif/ultrasonic_floor_tb.sv

/* verif/ultrasonic_floor_assert.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module ultrasonic_floor_assert (
    input logic clock,
    input logic reset,
    input logic trigger,
    input logic done,
    input logic timeout
);

    logic [7:0] high_count;

    // Failed assertions so far, read by the testbench at the end
    int assert_failures = 0;

    // Number of clocks the trigger has been high so far
    always_ff @(posedge clock) begin
        if (reset || !trigger) begin
            high_count <= '0;
        end else begin
            high_count <= high_count + 8'd1;
        end
    end

    // ====================
    // Trigger width
    // ====================

    trigger_width_exact: assert property (@(posedge clock) disable iff (reset)
        $fell(trigger) |-> high_count == 8'(`TRIGGER_CYCLES))
        else begin
            assert_failures++;
            $error("trigger pulse ended after the wrong number of clocks");
        end

    trigger_width_bound: assert property (@(posedge clock) disable iff (reset)
        trigger |-> high_count < 8'(`TRIGGER_CYCLES))
        else begin
            assert_failures++;
            $error("trigger pulse is longer than allowed");
        end

    // ====================
    // End of measurement
    // ====================

    done_one_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else begin
            assert_failures++;
            $error("done is high for more than one clock");
        end

    timeout_one_cycle: assert property (@(posedge clock) disable iff (reset)
        timeout |=> !timeout)
        else begin
            assert_failures++;
            $error("timeout is high for more than one clock");
        end

    done_timeout_apart: assert property (@(posedge clock) disable iff (reset)
        !(done && timeout))
        else begin
            assert_failures++;
            $error("done and timeout are high together");
        end

    // A new trigger may only follow a finished measurement
    trigger_not_with_done: assert property (@(posedge clock) disable iff (reset)
        !(trigger && done))
        else begin
            assert_failures++;
            $error("trigger is high while done is high");
        end

endmodule

`default_nettype wire

/* verif/ultrasonic_floor_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ultrasonic_floor_settings.svh"

module ultrasonic_floor_tb;

    localparam int end_limit     = 25000;
    localparam int trigger_limit = 50;

    logic                         clock;
    logic                         reset;
    logic                         measure;
    logic                         echo;
    logic                         trigger;
    ultrasonic_floor_pkg::seg7_t  hex0;
    ultrasonic_floor_pkg::seg7_t  hex1;
    ultrasonic_floor_pkg::seg7_t  hex2;
    ultrasonic_floor_pkg::seg7_t  hex3;
    ultrasonic_floor_pkg::floor_t floor_level;
    logic                         done;
    logic                         timeout;
    logic                         db_measure;
    logic                         db_echo;
    logic                         db_trigger;
    ultrasonic_floor_pkg::seg7_t  db_state;

    int     mismatches;
    int     failures;
    int     trigger_pulses;
    logic   trigger_q;
    integer seed;
    int     random_cm;
    int     boundary_cm [6] = '{9, 10, 19, 20, 29, 30};

    ultrasonic_floor_top uut (
        .clock      (clock),
        .reset      (reset),
        .measure    (measure),
        .echo       (echo),
        .trigger    (trigger),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .floor_level(floor_level),
        .done       (done),
        .timeout    (timeout),
        .db_measure (db_measure),
        .db_echo    (db_echo),
        .db_trigger (db_trigger),
        .db_state   (db_state)
    );

    bind ultrasonic_floor_top ultrasonic_floor_assert u_assert (
        .clock  (clock),
        .reset  (reset),
        .trigger(trigger),
        .done   (done),
        .timeout(timeout)
    );

    always #5 clock = ~clock;

    // Rising edges of trigger are counted on the falling clock edge
    always @(negedge clock) begin
        if (!reset && trigger && !trigger_q) begin
            trigger_pulses++;
        end
        trigger_q = trigger;
    end

    // ====================
    // Helpers
    // ====================

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            mismatches++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Maps an active-low pattern from g down to a back to its digit
    function automatic int segments_to_digit(ultrasonic_floor_pkg::seg7_t segments);
        case (segments)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return -1;
        endcase
    endfunction

    task automatic check_display(input string name, input int cm);
        int shown;
        int expected_floor;
        shown = (cm > `MAX_CM) ? `MAX_CM : cm;
        if (shown < `FLOOR1_CM) begin
            expected_floor = 0;
        end else if (shown < `FLOOR2_CM) begin
            expected_floor = 1;
        end else if (shown < `FLOOR3_CM) begin
            expected_floor = 2;
        end else begin
            expected_floor = 3;
        end
        check_value({name, " units"}, shown % 10, segments_to_digit(hex1));
        check_value({name, " tens"}, (shown / 10) % 10, segments_to_digit(hex2));
        check_value({name, " hundreds"}, shown / 100, segments_to_digit(hex3));
        check_value({name, " floor display"}, expected_floor, segments_to_digit(hex0));
        check_value({name, " floor level"}, expected_floor, int'(floor_level));
    endtask

    task automatic check_state(input string name, input ultrasonic_floor_pkg::sonar_state_t st);
        check_value({name, " state display"}, int'(st), segments_to_digit(db_state));
    endtask

    // Measure is held high for a few clocks and still gives a single edge
    task automatic start_measure();
        measure = 1'b1;
        repeat (3) next_cycle();
        measure = 1'b0;
    endtask

    task automatic wait_trigger_pulse(input string name);
        int count;
        count = 0;
        while (!trigger && count < trigger_limit) begin
            next_cycle();
            count++;
        end
        if (!trigger) begin
            failures++;
            $display("trigger did not rise after the measure edge");
        end else begin
            check_value({name, " trigger copy high"}, 1, int'(db_trigger));
        end
        count = 0;
        while (trigger && count < trigger_limit) begin
            next_cycle();
            count++;
        end
        if (trigger) begin
            failures++;
            $display("trigger did not fall again");
        end else begin
            check_value({name, " trigger copy low"}, 0, int'(db_trigger));
        end
    endtask

    task automatic wait_result(output logic saw_done, output logic saw_timeout);
        int count;
        count = 0;
        while (!done && !timeout && count < end_limit) begin
            next_cycle();
            count++;
        end
        saw_done    = done;
        saw_timeout = timeout;
        if (!done && !timeout) begin
            failures++;
            $display("neither done nor timeout came within %0d clocks", end_limit);
        end
    endtask

    // The echo lasts N cm plus half a centimetre so the reading is exactly N
    task automatic measure_distance(input string name, input int cm, input logic retrigger);
        logic saw_done;
        logic saw_timeout;
        int   pulses_before;
        int   length;
        pulses_before = trigger_pulses;
        length        = cm * `CM_CYCLES + `CM_CYCLES / 2;
        start_measure();
        wait_trigger_pulse(name);
        repeat (3) next_cycle();
        echo = 1'b1;
        for (int i = 0; i < length; i++) begin
            measure = retrigger && (i >= 4) && (i < 8);
            next_cycle();
            if (i == 4) begin
                check_value({name, " echo copy"}, 1, int'(db_echo));
                check_value({name, " measure copy"}, int'(retrigger), int'(db_measure));
                check_state(name, ultrasonic_floor_pkg::st_measure);
            end
        end
        echo    = 1'b0;
        measure = 1'b0;
        wait_result(saw_done, saw_timeout);
        check_value({name, " done"}, 1, int'(saw_done));
        check_value({name, " timeout"}, 0, int'(saw_timeout));
        check_value({name, " echo copy low"}, 0, int'(db_echo));
        check_value({name, " measure copy low"}, 0, int'(db_measure));
        check_state(name, ultrasonic_floor_pkg::st_done);
        check_display(name, cm);
        next_cycle();
        check_value({name, " trigger pulses"}, pulses_before + 1, trigger_pulses);
    endtask

    task automatic measure_without_echo(input string name, input int previous_cm);
        logic saw_done;
        logic saw_timeout;
        start_measure();
        wait_trigger_pulse(name);
        wait_result(saw_done, saw_timeout);
        check_value({name, " done"}, 0, int'(saw_done));
        check_value({name, " timeout"}, 1, int'(saw_timeout));
        check_state(name, ultrasonic_floor_pkg::st_idle);
        check_display(name, previous_cm);
        next_cycle();
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        measure        = 1'b0;
        echo           = 1'b0;
        mismatches     = 0;
        failures       = 0;
        trigger_pulses = 0;
        trigger_q      = 1'b0;
        seed           = 32'h49e5ae1b;
        repeat (2) next_cycle();
        reset = 1'b0;
        next_cycle();

        check_value("reset trigger", 0, int'(trigger));
        check_value("reset done", 0, int'(done));
        check_value("reset timeout", 0, int'(timeout));
        check_state("reset", ultrasonic_floor_pkg::st_idle);
        check_display("reset", 0);

        measure_distance("distance 0", 0, 1'b0);
        measure_distance("distance 7 with second edge", 7, 1'b1);
        measure_distance("distance 25", 25, 1'b0);
        measure_distance("distance 123", 123, 1'b0);
        for (int k = 0; k < 3; k++) begin
            random_cm = $unsigned($random(seed)) % 999;
            measure_distance($sformatf("random %0d", random_cm), random_cm, 1'b0);
        end

        foreach (boundary_cm[i]) begin
            measure_distance($sformatf("floor at %0d", boundary_cm[i]), boundary_cm[i], 1'b0);
        end

        // The last reading was 30 cm and must survive the timeout
        measure_without_echo("no echo", 30);
        measure_distance("saturation", 1005, 1'b0);

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, uut.u_assert.assert_failures);
        if (mismatches == 0 && failures == 0 && uut.u_assert.assert_failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
